// File: design/axil_calc_regs.sv
`timescale 1ns/1ns

module axil_calc_regs (
    input  logic                CLK10Hz,
    input  logic                reset,
    input  calc_pkg::axil_req_t axil_req,
    output calc_pkg::axil_rsp_t axil_rsp,
    output logic                alu_start,
    output calc_pkg::alu_req_t  alu_req,
    input  logic                alu_done,
    input  calc_pkg::alu_rsp_t  alu_rsp,
    output calc_pkg::bcd4_t     opa,
    output calc_pkg::bcd8_t     result,
    output calc_pkg::disp_sel_t disp
);

    logic            aw_ready;   // shared by aw and w channels
    logic            b_valid;
    logic [1:0]      b_resp;
    logic            ar_ready;
    logic            r_valid;
    logic [1:0]      r_resp;
    logic [31:0]     r_data;
    calc_pkg::bcd4_t opb;
    logic            busy;
    logic            done;
    logic            error;
    logic            busy_any;   // includes the start pulse cycle
    logic            wr_fire;
    logic            rd_fire;
    logic            start_req;
    logic            start_ok;
    logic [1:0]      wr_resp;
    logic [31:0]     rd_data;
    logic            rd_err;

    assign wr_fire   = aw_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire   = ar_ready && axil_req.arvalid;
    assign busy_any  = busy || alu_start;
    assign start_req = wr_fire && (axil_req.awaddr == calc_pkg::REG_CTRL) &&
                       axil_req.wstrb[0] && axil_req.wdata[0];
    assign start_ok  = start_req && !busy_any;

    always_comb begin
        case (axil_req.awaddr)
            calc_pkg::REG_OPA, calc_pkg::REG_OPB, calc_pkg::REG_STATUS,
            calc_pkg::REG_RESULT, calc_pkg::REG_DISP: wr_resp = calc_pkg::RESP_OKAY;
            calc_pkg::REG_CTRL: wr_resp = (start_req && busy_any) ? calc_pkg::RESP_SLVERR
                                                                  : calc_pkg::RESP_OKAY;
            default: wr_resp = calc_pkg::RESP_SLVERR; // unmapped
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (axil_req.araddr)
            calc_pkg::REG_OPA:    rd_data = {16'h0, opa};
            calc_pkg::REG_OPB:    rd_data = {16'h0, opb};
            calc_pkg::REG_CTRL:   rd_data = {30'h0, alu_req.op, 1'b0}; // start reads as 0
            calc_pkg::REG_STATUS: rd_data = {29'h0, error, done, busy_any};
            calc_pkg::REG_RESULT: rd_data = result;
            calc_pkg::REG_DISP:   rd_data = {30'h0, disp.advance, disp.select};
            default:              rd_err  = 1'b1;
        endcase
    end

    // write channel handshake
    always_ff @(posedge CLK10Hz or posedge reset) begin
        if (reset) begin
            aw_ready <= 1'b0;
            b_valid  <= 1'b0;
            b_resp   <= calc_pkg::RESP_OKAY;
        end else begin
            aw_ready <= axil_req.awvalid && axil_req.wvalid && !aw_ready && !b_valid;
            if (wr_fire) begin
                b_valid <= 1'b1;
                b_resp  <= wr_resp;
            end else if (b_valid && axil_req.bready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // read channel handshake
    always_ff @(posedge CLK10Hz or posedge reset) begin
        if (reset) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_resp   <= calc_pkg::RESP_OKAY;
        end else begin
            ar_ready <= axil_req.arvalid && !ar_ready && !r_valid;
            if (rd_fire) begin
                r_valid <= 1'b1;
                r_resp  <= rd_err ? calc_pkg::RESP_SLVERR : calc_pkg::RESP_OKAY;
            end else if (r_valid && axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK10Hz) begin
        if (rd_fire) r_data <= rd_data;
    end

    // register file, start and status
    always_ff @(posedge CLK10Hz or posedge reset) begin
        if (reset) begin
            opa       <= '0;
            opb       <= '0;
            result    <= '0;
            disp      <= '0;
            alu_req   <= '0;
            alu_start <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            alu_start <= start_ok;
            if (alu_start) busy <= 1'b1;
            if (alu_done) begin
                busy  <= 1'b0;
                done  <= 1'b1;
                error <= alu_rsp.error;
                if (!alu_rsp.error) result <= alu_rsp.result; // keep last good result
            end
            if (start_ok) begin
                alu_req.op <= calc_pkg::calc_op_t'(axil_req.wdata[1]);
                alu_req.a  <= opa;
                alu_req.b  <= opb;
                done       <= 1'b0;
            end
            if (wr_fire) begin
                for (int i = 0; i < 2; i++) begin
                    if (axil_req.wstrb[i] && axil_req.awaddr == calc_pkg::REG_OPA)
                        opa[8*i +: 8] <= axil_req.wdata[8*i +: 8];
                    if (axil_req.wstrb[i] && axil_req.awaddr == calc_pkg::REG_OPB)
                        opb[8*i +: 8] <= axil_req.wdata[8*i +: 8];
                end
                if (axil_req.wstrb[0] && axil_req.awaddr == calc_pkg::REG_DISP) begin
                    disp.select  <= axil_req.wdata[0];
                    disp.advance <= axil_req.wdata[1];
                end
            end
        end
    end

    always_comb begin
        axil_rsp.awready = aw_ready;
        axil_rsp.wready  = aw_ready;
        axil_rsp.bresp   = b_resp;
        axil_rsp.bvalid  = b_valid;
        axil_rsp.arready = ar_ready;
        axil_rsp.rdata   = r_data;
        axil_rsp.rresp   = r_resp;
        axil_rsp.rvalid  = r_valid;
    end

endmodule

// File: design/bcd_alu.sv
`timescale 1ns/1ns

module bcd_alu (
    input  logic               CLK10Hz,
    input  logic               reset,
    input  logic               start,
    input  calc_pkg::alu_req_t req,
    output logic               done,
    output calc_pkg::alu_rsp_t rsp
);

    typedef enum logic [2:0] {S_IDLE, S_ADD, S_MDIG, S_MADD, S_FIN} state_t;

    state_t          state;
    calc_pkg::bcd8_t acc;       // running sum or operand a for add
    calc_pkg::bcd8_t mcand;     // shifted multiplicand or operand b for add
    calc_pkg::bcd4_t mplier;    // remaining multiplier digits with the lowest first
    logic [3:0]      cnt;       // adds left for the current digit
    logic [1:0]      dig_idx;
    calc_pkg::bcd8_t sum;
    logic            ops_ok;
    logic            adv;       // move to the next multiplier digit
    logic            last_dig;

    function automatic logic is_bcd(input calc_pkg::bcd4_t v);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (v[4*i +: 4] > 4'd9) ok = 1'b0;
        end
        return ok;
    endfunction

    assign ops_ok   = is_bcd(req.a) && is_bcd(req.b);
    assign last_dig = (dig_idx == 2'd3);
    assign adv      = (state == S_MDIG && mplier[3:0] == 4'd0) ||
                      (state == S_MADD && cnt == 4'd1);

    // eight digit adder with ripple decimal carry
    always_comb begin
        logic [4:0] dsum;
        logic       carry;
        carry = 1'b0;
        for (int i = 0; i < 8; i++) begin
            dsum = {1'b0, acc[4*i +: 4]} + {1'b0, mcand[4*i +: 4]} + {4'd0, carry};
            carry = (dsum > 5'd9);
            if (carry) dsum = dsum + 5'd6; // decimal correction
            sum[4*i +: 4] = dsum[3:0];
        end
    end

    always_ff @(posedge CLK10Hz or posedge reset) begin
        if (reset) begin
            state   <= S_IDLE;
            done    <= 1'b0;
            dig_idx <= 2'd0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    dig_idx <= 2'd0;
                    if (start && !ops_ok) done <= 1'b1; // reject at once
                    else if (start) state <= (req.op == calc_pkg::OP_ADD) ? S_ADD : S_MDIG;
                end
                S_ADD: begin
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                S_MDIG, S_MADD: begin
                    if (adv) begin
                        dig_idx <= dig_idx + 2'd1;
                        state   <= last_dig ? S_FIN : S_MDIG;
                    end else if (state == S_MDIG) begin
                        state <= S_MADD;
                    end
                end
                default: begin // S_FIN
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK10Hz) begin
        case (state)
            S_IDLE: if (start) begin
                acc        <= (req.op == calc_pkg::OP_ADD) ? {16'h0, req.a} : '0;
                mcand      <= (req.op == calc_pkg::OP_ADD) ? {16'h0, req.b} : {16'h0, req.a};
                mplier     <= req.b;
                rsp.result <= '0;
                rsp.error  <= !ops_ok;
            end
            S_ADD:  rsp.result <= sum;
            S_MDIG: if (!adv) cnt <= mplier[3:0];
            S_MADD: begin
                acc <= sum;
                cnt <= cnt - 4'd1;
            end
            default: rsp.result <= acc;
        endcase
        if (adv) begin
            mcand  <= mcand << 4;   // next decimal position
            mplier <= mplier >> 4;
        end
    end

endmodule

// File: design/calc_pkg.sv
package calc_pkg;

    localparam int AXIL_ADDR_W = 5;

    // register map in byte offsets
    localparam logic [AXIL_ADDR_W-1:0] REG_OPA    = 5'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_OPB    = 5'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 5'h08; // bit0 start, bit1 op
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 5'h0C; // bit0 busy, bit1 done, bit2 error
    localparam logic [AXIL_ADDR_W-1:0] REG_RESULT = 5'h10;
    localparam logic [AXIL_ADDR_W-1:0] REG_DISP   = 5'h14; // bit0 select, bit1 advance

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [6:0] SEG_BLANK = 7'h7f; // all active low segments off

    localparam logic [1:0] LED_LOW_HALF  = 2'b00; // operand or lower result digits
    localparam logic [1:0] LED_HIGH_HALF = 2'b01; // upper result digits

    typedef logic [15:0] bcd4_t;
    typedef logic [31:0] bcd8_t;
    typedef logic [3:0][3:0] digits_t; // [0] is the ones digit

    typedef enum logic {OP_ADD = 1'b0, OP_MUL = 1'b1} calc_op_t;

    typedef struct packed {
        calc_op_t op;
        bcd4_t    a;
        bcd4_t    b;
    } alu_req_t;

    typedef struct packed {
        bcd8_t result;
        logic  error;
    } alu_rsp_t;

    typedef struct packed {
        logic select;  // 0 input, 1 result
        logic advance; // upper four result digits
    } disp_sel_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // bit 6 is segment a and bit 0 is segment g
    function automatic logic [6:0] seg_decode(input logic [3:0] digit);
        case (digit)
            4'd0: return 7'b0000001;
            4'd1: return 7'b1001111;
            4'd2: return 7'b0010010;
            4'd3: return 7'b0000110;
            4'd4: return 7'b1001100;
            4'd5: return 7'b0100100;
            4'd6: return 7'b0100000;
            4'd7: return 7'b0001111;
            4'd8: return 7'b0000000;
            4'd9: return 7'b0000100;
            default: return SEG_BLANK; // not a decimal digit
        endcase
    endfunction

endpackage

// File: design/calc_top.sv
`timescale 1ns/1ns

module calc_top (
    input  logic                CLK10Hz,
    input  logic                reset,
    input  calc_pkg::axil_req_t axil_req,
    output calc_pkg::axil_rsp_t axil_rsp,
    output logic [6:0]          seg_out,
    output logic [3:0]          an_out,
    output logic [1:0]          leds_out
);

    logic                alu_start;
    calc_pkg::alu_req_t  alu_req;
    logic                alu_done;
    calc_pkg::alu_rsp_t  alu_rsp;
    calc_pkg::bcd4_t     opa;
    calc_pkg::bcd8_t     result;
    calc_pkg::disp_sel_t disp;
    calc_pkg::digits_t   digits;

    // host registers, start rules and status
    axil_calc_regs u_regs (
        .CLK10Hz  (CLK10Hz),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .alu_start(alu_start),
        .alu_req  (alu_req),
        .alu_done (alu_done),
        .alu_rsp  (alu_rsp),
        .opa      (opa),
        .result   (result),
        .disp     (disp)
    );

    bcd_alu u_alu (
        .CLK10Hz(CLK10Hz),
        .reset  (reset),
        .start  (alu_start),
        .req    (alu_req),
        .done   (alu_done),
        .rsp    (alu_rsp)
    );

    display_select u_disp_sel (
        .CLK10Hz(CLK10Hz),
        .reset  (reset),
        .opa    (opa),
        .result (result),
        .disp   (disp),
        .digits (digits),
        .leds   (leds_out)
    );

    seg7_scan u_scan (
        .CLK10Hz(CLK10Hz),
        .reset  (reset),
        .digits (digits),
        .seg_out(seg_out),
        .an_out (an_out)
    );

endmodule

// File: design/display_select.sv
`timescale 1ns/1ns

module display_select (
    input  logic                CLK10Hz,
    input  logic                reset,
    input  calc_pkg::bcd4_t     opa,
    input  calc_pkg::bcd8_t     result,
    input  calc_pkg::disp_sel_t disp,
    output calc_pkg::digits_t   digits,
    output logic [1:0]          leds
);

    calc_pkg::bcd4_t shown;  // four digits picked this cycle
    logic [1:0]      mode;

    always_comb begin
        if (!disp.select) begin
            shown = opa;                      // operand entry view
            mode  = calc_pkg::LED_LOW_HALF;
        end else if (disp.advance) begin
            shown = result[31:16];
            mode  = calc_pkg::LED_HIGH_HALF;
        end else begin
            shown = result[15:0];
            mode  = calc_pkg::LED_LOW_HALF;
        end
    end

    // LEDs report which view is on the digits
    always_ff @(posedge CLK10Hz or posedge reset) begin
        if (reset) begin
            leds <= calc_pkg::LED_LOW_HALF;
        end else begin
            leds <= mode;
        end
    end

    // digits pass through untouched and bad nibbles blank in the decoder
    always_ff @(posedge CLK10Hz) begin
        digits <= calc_pkg::digits_t'(shown);
    end

endmodule

// File: design/seg7_scan.sv
`timescale 1ns/1ns

module seg7_scan (
    input  logic              CLK10Hz,
    input  logic              reset,
    input  calc_pkg::digits_t digits,
    output logic [6:0]        seg_out,
    output logic [3:0]        an_out
);

    logic [1:0] scan_idx;   // digit currently lit
    logic [1:0] next_idx;

    assign next_idx = scan_idx + 2'd1;

    // one anode low at a time starting with the ones digit
    always_ff @(posedge CLK10Hz or posedge reset) begin
        if (reset) begin
            scan_idx <= 2'd3;    // wraps to the ones digit on the first edge
            an_out   <= 4'b1111; // all digits dark
        end else begin
            scan_idx <= next_idx;
            an_out   <= ~(4'b0001 << next_idx);
        end
    end

    // segments track the lit anode in the same cycle
    assign seg_out = calc_pkg::seg_decode(digits[scan_idx]);

endmodule

// File: project.f
design/calc_pkg.sv
design/axil_calc_regs.sv
design/bcd_alu.sv
design/display_select.sv
design/seg7_scan.sv
design/calc_top.sv
verif/clock_gen.sv
verif/calc_properties.sv
verif/calc_tb.sv

// File: verif/calc_cases.txt
// columns: op (0 add, 1 mul), operand a, operand b, expected result, error flag
// on error lines the result column is the previous result, which must stay
0 1234 4321 00005555 0
0 9999 0001 00010000 0
0 5678 8765 00014443 0
1 0012 0034 00000408 0
1 0250 0004 00001000 0
1 1234 5678 07006652 0
0 12a4 0001 07006652 1
1 9999 9999 99980001 0
1 0000 9999 00000000 0
1 0070 00f3 00000000 1
0 0000 0000 00000000 0

// File: verif/calc_properties.sv
`timescale 1ns/1ns

module calc_properties (
    input logic CLK10Hz,
    input logic reset,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic busy,
    input logic alu_done
);

    int assert_fails = 0; // read by the testbench at the end

    // write response waits for the host
    bvalid_hold: assert property (@(posedge CLK10Hz) disable iff (reset)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        assert_fails++;
    end

    rvalid_hold: assert property (@(posedge CLK10Hz) disable iff (reset)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        assert_fails++;
    end

    // only the ALU done pulse ends a busy phase
    busy_until_done: assert property (@(posedge CLK10Hz) disable iff (reset)
        busy && !alu_done |=> busy)
    else begin
        $error("busy fell without alu_done");
        assert_fails++;
    end

endmodule

bind axil_calc_regs calc_properties u_props (
    .CLK10Hz (CLK10Hz),
    .reset   (reset),
    .bvalid  (axil_rsp.bvalid),
    .bready  (axil_req.bready),
    .rvalid  (axil_rsp.rvalid),
    .rready  (axil_req.rready),
    .busy    (busy),
    .alu_done(alu_done)
);

// File: verif/calc_tb.sv
`timescale 1ns/1ns

module calc_tb;

    localparam int MAX_CASES       = 32;
    localparam int RAND_CASES      = 8;
    localparam int FIXED_TESTS     = 7; // reset, unmapped, busy, four display
    localparam int CYCLES_PER_TEST = 80;

    logic                CLK10Hz;
    logic                reset;
    calc_pkg::axil_req_t axil_req;
    calc_pkg::axil_rsp_t axil_rsp;
    logic [6:0]          seg_out;
    logic [3:0]          an_out;
    logic [1:0]          leds_out;

    logic [31:0]     case_mem [0:5*MAX_CASES-1]; // five words per case
    logic [31:0]     lfsr_state = 32'h3d85;
    calc_pkg::bcd8_t last_result;               // last good result the DUT must hold
    int              n_cases = 0;
    int              cycle_limit = 0;
    int              cycles = 0;
    int              tests = 0;
    int              failed_tests = 0;
    int              checks = 0;
    int              errors = 0;
    int              test_start_errors = 0;

    clock_gen u_clock_gen (
        .CLK10Hz(CLK10Hz),
        .reset  (reset)
    );

    calc_top u_calc_top (
        .CLK10Hz (CLK10Hz),
        .reset   (reset),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .seg_out (seg_out),
        .an_out  (an_out),
        .leds_out(leds_out)
    );

    always @(posedge CLK10Hz) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int bcd_value(input calc_pkg::bcd8_t v);
        int n;
        n = 0;
        for (int i = 7; i >= 0; i--) n = n * 10 + v[4*i +: 4];
        return n;
    endfunction

    function automatic calc_pkg::bcd8_t to_bcd8(input int n);
        calc_pkg::bcd8_t v;
        int              rest;
        rest = n;
        for (int i = 0; i < 8; i++) begin
            v[4*i +: 4] = rest % 10;
            rest = rest / 10;
        end
        return v;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bcd4(output calc_pkg::bcd4_t v);
        logic [3:0] nib;
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < 4; k++) begin
                nib[k]     = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
            v[4*d +: 4] = nib % 10; // keep it a decimal digit
        end
    endtask

    // active low pattern back to a digit with 4'hf for blank and 4'he for unknown
    function automatic logic [3:0] seg_to_digit(input logic [6:0] seg);
        case (seg)
            7'h01: return 4'd0;
            7'h4f: return 4'd1;
            7'h12: return 4'd2;
            7'h06: return 4'd3;
            7'h4c: return 4'd4;
            7'h24: return 4'd5;
            7'h20: return 4'd6;
            7'h0f: return 4'd7;
            7'h00: return 4'd8;
            7'h04: return 4'd9;
            7'h7f: return 4'hf;
            default: return 4'he;
        endcase
    endfunction

    task automatic write_reg(input logic [calc_pkg::AXIL_ADDR_W-1:0] addr,
                             input logic [31:0] data, output logic [1:0] resp);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        do @(negedge CLK10Hz); while (!axil_rsp.awready);
        checks++;
        if (axil_rsp.wready !== 1'b1) begin
            errors++;
            $display("Error at %0t: wready %b while awready is high, expected 1",
                     $time, axil_rsp.wready);
        end
        @(negedge CLK10Hz); // handshake on the edge in between
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        while (!axil_rsp.bvalid) @(negedge CLK10Hz);
        resp = axil_rsp.bresp;
        @(negedge CLK10Hz);
        axil_req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [calc_pkg::AXIL_ADDR_W-1:0] addr,
                            output logic [31:0] data, output logic [1:0] resp);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        do @(negedge CLK10Hz); while (!axil_rsp.arready);
        @(negedge CLK10Hz);
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        while (!axil_rsp.rvalid) @(negedge CLK10Hz);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(negedge CLK10Hz);
        axil_req.rready = 1'b0;
    endtask

    task automatic poll_done(output logic [31:0] status);
        logic [1:0] resp;
        status = '0;
        while (!status[1]) read_reg(calc_pkg::REG_STATUS, status, resp);
    endtask

    task automatic check_result(input string what, input calc_pkg::bcd8_t got,
                                input calc_pkg::bcd8_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s result %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input string what, input logic got_err, input logic exp_err,
                                input logic [1:0] got_resp, input logic [1:0] exp_resp);
        checks++;
        if (got_err !== exp_err || got_resp !== exp_resp) begin
            errors++;
            $display("Error at %0t: %s error bit %b resp %b, expected %b resp %b",
                     $time, what, got_err, got_resp, exp_err, exp_resp);
        end
    endtask

    task automatic check_display(input string what, input calc_pkg::digits_t exp_digits,
                                 input logic [1:0] exp_leds);
        calc_pkg::digits_t want;
        calc_pkg::digits_t seen;
        logic [3:0]        lit;
        logic [1:0]        leds;
        int                first_j;
        logic              in_order;
        seen     = '1;
        lit      = '0;
        first_j  = 0;
        in_order = 1'b1;
        for (int i = 0; i < 4; i++) want[i] = (exp_digits[i] > 4'd9) ? 4'hf : exp_digits[i];
        repeat (2) @(negedge CLK10Hz); // select register, then digit register
        leds = leds_out;
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                if (an_out == ~(4'b0001 << j)) begin
                    seen[j] = seg_to_digit(seg_out);
                    lit[j]  = 1'b1;
                    // each cycle lights the next digit up
                    if (k == 0) first_j = j;
                    else if (j != (first_j + k) % 4) in_order = 1'b0;
                end
            end
            @(negedge CLK10Hz);
        end
        checks++;
        if (lit !== 4'hf || !in_order) begin
            errors++;
            $display("%s: the scan did not light one digit per cycle from ones up (lit %b)",
                     what, lit);
        end
        checks++;
        if (seen !== want || leds !== exp_leds) begin
            errors++;
            $display("Error at %0t: %s digits %h leds %b, expected %h leds %b",
                     $time, what, seen, leds, want, exp_leds);
        end
    endtask

    task automatic check_reset(input calc_pkg::axil_rsp_t rsp, input logic [1:0] leds,
                               input logic [3:0] an);
        checks++;
        if (rsp.bvalid !== 1'b0 || rsp.rvalid !== 1'b0 || leds !== 2'b00 || an !== 4'b1111) begin
            errors++;
            $display("Error at %0t: after reset bvalid %b rvalid %b leds %b, anodes in reset %b",
                     $time, rsp.bvalid, rsp.rvalid, leds, an);
        end
    endtask

    task automatic open_test();
        test_start_errors = errors;
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    task automatic run_calc(input string name, input logic op, input calc_pkg::bcd4_t a,
                            input calc_pkg::bcd4_t b, input calc_pkg::bcd8_t exp_res,
                            input logic exp_err);
        logic [1:0]  resp;
        logic [1:0]  ctrl_resp;
        logic [31:0] rd;
        open_test();
        write_reg(calc_pkg::REG_OPA, {16'h0, a}, resp);
        write_reg(calc_pkg::REG_OPB, {16'h0, b}, resp);
        write_reg(calc_pkg::REG_CTRL, {30'h0, op, 1'b1}, ctrl_resp);
        poll_done(rd);
        check_status(name, rd[2], exp_err, ctrl_resp, calc_pkg::RESP_OKAY);
        read_reg(calc_pkg::REG_RESULT, rd, resp);
        check_result(name, rd, exp_res); // error cases expect the old result
        if (!exp_err) last_result = exp_res;
        close_test(name);
    endtask

    initial begin
        logic [31:0]     rd;
        logic [31:0]     status;
        logic [1:0]      resp;
        logic [1:0]      resp2;
        logic [3:0]      an_in_reset;
        calc_pkg::bcd4_t ra;
        calc_pkg::bcd4_t rb;
        calc_pkg::bcd8_t exp_prod;

        axil_req = '0;
        $readmemh("verif/calc_cases.txt", case_mem);
        while (n_cases < MAX_CASES && !$isunknown(case_mem[5*n_cases])) n_cases++;
        cycle_limit = (n_cases + RAND_CASES + FIXED_TESTS) * CYCLES_PER_TEST + 16;
        if (n_cases == 0) begin
            errors++;
            $display("no cases could be read from verif/calc_cases.txt");
        end

        @(negedge CLK10Hz);
        an_in_reset = an_out;
        while (reset) @(negedge CLK10Hz);

        open_test();
        check_reset(axil_rsp, leds_out, an_in_reset);
        close_test("reset state");

        open_test();
        read_reg(5'h18, rd, resp); // no register there
        read_reg(calc_pkg::REG_STATUS, status, resp2);
        check_status("unmapped read", status[2], 1'b0, resp, calc_pkg::RESP_SLVERR);
        check_status("status read", status[2], 1'b0, resp2, calc_pkg::RESP_OKAY);
        close_test("unmapped read");

        for (int i = 0; i < n_cases; i++) begin
            run_calc($sformatf("file case %0d", i), case_mem[5*i][0], case_mem[5*i+1][15:0],
                     case_mem[5*i+2][15:0], case_mem[5*i+3], case_mem[5*i+4][0]);
        end

        for (int i = 0; i < RAND_CASES; i++) begin
            rand_bcd4(ra);
            rand_bcd4(rb);
            run_calc($sformatf("random add %0d", i), calc_pkg::OP_ADD, ra, rb,
                     to_bcd8(bcd_value({16'h0, ra}) + bcd_value({16'h0, rb})), 1'b0);
        end

        // second start lands during a 42 cycle multiply
        open_test();
        write_reg(calc_pkg::REG_OPA, 32'h9999, resp);
        write_reg(calc_pkg::REG_OPB, 32'h9999, resp);
        write_reg(calc_pkg::REG_CTRL, 32'h3, resp);
        write_reg(calc_pkg::REG_CTRL, 32'h1, resp2);
        poll_done(status);
        check_status("first start", status[2], 1'b0, resp, calc_pkg::RESP_OKAY);
        check_status("start while busy", status[2], 1'b0, resp2, calc_pkg::RESP_SLVERR);
        exp_prod = to_bcd8(bcd_value(32'h9999) * bcd_value(32'h9999));
        read_reg(calc_pkg::REG_RESULT, rd, resp);
        check_result("start while busy", rd, exp_prod);
        last_result = exp_prod;
        close_test("start while busy");

        open_test();
        write_reg(calc_pkg::REG_OPA, 32'h2019, resp);
        write_reg(calc_pkg::REG_DISP, 32'h0, resp);
        check_display("operand view", 16'h2019, 2'b00);
        close_test("display operand");

        open_test();
        write_reg(calc_pkg::REG_OPA, 32'h7a31, resp); // hundreds nibble is not a digit
        check_display("blank digit", 16'h7a31, 2'b00);
        close_test("display blank digit");

        open_test();
        write_reg(calc_pkg::REG_DISP, 32'h1, resp);
        check_display("lower result", last_result[15:0], 2'b00);
        close_test("display lower result");

        open_test();
        write_reg(calc_pkg::REG_DISP, 32'h3, resp);
        check_display("upper result", last_result[31:16], 2'b01);
        close_test("display upper result");

        if (u_calc_top.u_regs.u_props.assert_fails != 0) begin
            errors += u_calc_top.u_regs.u_props.assert_fails;
            $display("%0d assertion failures in the register slave",
                     u_calc_top.u_regs.u_props.assert_fails);
        end

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests - failed_tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic CLK10Hz,
    output logic reset
);

    initial begin
        CLK10Hz = 1'b0;
        forever #50 CLK10Hz = ~CLK10Hz; // 100 ns period
    end

    // reset spans the first 16 rising edges and drops on the next falling edge
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge CLK10Hz);
        @(negedge CLK10Hz);
        reset = 1'b0;
    end

endmodule
